// File: vlog.f
softmax_pkg.sv
softmax_divider.sv
softmax_scalar_unit.sv
softmax_vector_function.sv
softmax_tb_assertions.sv
softmax_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the softmax testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module softmax_tb -f vlog.f -o Vsoftmax_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vsoftmax_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: softmax_tb.sv
// Softmax accelerator testbench
`timescale 1ns/100ps
`default_nettype none

module softmax_tb
  import softmax_pkg::*;
();

  localparam int TABLE_JOBS = 6;
  localparam int RANDOM_JOBS = 4;
  localparam int NUM_JOBS = TABLE_JOBS + RANDOM_JOBS;
  localparam int MAX_VECTORS = 4;

  logic  CLK;
  logic  RST;
  logic  start;
  data_t size_in;
  data_t length_in;
  logic  data_in_vector_enable;
  logic  data_in_scalar_enable;
  data_t data_in;
  logic  data_out_vector_enable;
  logic  data_out_scalar_enable;
  data_t data_out;
  logic  ready;

  // Job table, one 64-bit word of 4-bit scores per vector
  int          job_size [NUM_JOBS];
  int          job_length [NUM_JOBS];
  logic [63:0] job_scores [NUM_JOBS][MAX_VECTORS];
  // Hand-worked first result of each table job
  data_t       job_first [NUM_JOBS];

  // Expected results in output order
  data_t exp_data_q [$];
  logic  exp_vec_q [$];
  logic  exp_rdy_q [$];

  int error_count = 0;
  int check_count = 0;
  int result_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  softmax_vector_function u_softmax_vector_function (
    .CLK                    (CLK),
    .RST                    (RST),
    .start                  (start),
    .size_in                (size_in),
    .length_in              (length_in),
    .data_in_vector_enable  (data_in_vector_enable),
    .data_in_scalar_enable  (data_in_scalar_enable),
    .data_in                (data_in),
    .data_out_vector_enable (data_out_vector_enable),
    .data_out_scalar_enable (data_out_scalar_enable),
    .data_out               (data_out),
    .ready                  (ready)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [SCORE_BITS-1:0] score_of(logic [63:0] vec, int e);
    return vec[SCORE_BITS*e +: SCORE_BITS];
  endfunction

  // floor(2^(x+FRAC_BITS) / sum of 2^x over the vector)
  function automatic data_t model_result(logic [63:0] vec, int len, int e);
    longint sum;
    longint num;
    sum = 0;
    for (int i = 0; i < len; i++) begin
      sum += longint'(1) << int'(score_of(vec, i));
    end
    num = longint'(1) << (int'(score_of(vec, e)) + FRAC_BITS);
    return data_t'(num / sum);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_data(string name, data_t got, data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  ////////////////////
  // Job table
  ////////////////////

  task automatic set_job(int j, int size, int len, data_t first, logic [63:0] v0,
                         logic [63:0] v1, logic [63:0] v2, logic [63:0] v3);
    job_size[j] = size;
    job_length[j] = len;
    job_first[j] = first;
    job_scores[j][0] = v0;
    job_scores[j][1] = v1;
    job_scores[j][2] = v2;
    job_scores[j][3] = v3;
  endtask

  task automatic load_table();
    // Single element, full scale
    set_job(0, 1, 1, 32'h0001_0000, 64'h0, 64'h0, 64'h0, 64'h0);
    // Equal scores give 65536 / L
    set_job(1, 1, 5, 32'h0000_3333, 64'h7_7777, 64'h0, 64'h0, 64'h0);
    // Scores 0 1 2 3 over a sum of 15
    set_job(2, 1, 4, 32'h0000_1111, 64'h3210, 64'h0, 64'h0, 64'h0);
    // Several vectors
    set_job(3, 3, 3, 32'h0000_5555, 64'h222, 64'h305, 64'h1EF, 64'h0);
    // Largest sum, then every score once
    set_job(4, 2, 16, 32'h0000_1000, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFEDC_BA98_7654_3210,
            64'h0, 64'h0);
    set_job(5, 4, 2, 32'h0000_AAAA, 64'h01, 64'h44, 64'h9C, 64'hF0);
  endtask

  task automatic make_random_jobs();
    for (int j = TABLE_JOBS; j < NUM_JOBS; j++) begin
      job_size[j] = int'($urandom_range(MAX_VECTORS, 1));
      job_length[j] = int'($urandom_range(MAX_LENGTH, 1));
      job_first[j] = '0;
      for (int v = 0; v < MAX_VECTORS; v++) begin
        job_scores[j][v] = {$urandom(), $urandom()};
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic queue_expected(int j);
    data_t value;
    for (int v = 0; v < job_size[j]; v++) begin
      for (int e = 0; e < job_length[j]; e++) begin
        value = model_result(job_scores[j][v], job_length[j], e);
        if (j < TABLE_JOBS && v == 0 && e == 0 && value != job_first[j]) begin
          $display("Model gives 0x%08h but table job %0d lists 0x%08h", value, j,
                   job_first[j]);
          error_count++;
        end
        exp_data_q.push_back(value);
        exp_vec_q.push_back(e == job_length[j] - 1);
        exp_rdy_q.push_back((e == job_length[j] - 1) && (v == job_size[j] - 1));
      end
    end
  endtask

  // Upper bits carry noise that the DUT must drop
  task automatic send_element(logic [SCORE_BITS-1:0] score, logic first, int gap);
    data_t noise;
    noise = data_t'($urandom());
    data_in = {noise[DATA_SIZE-1:SCORE_BITS], score};
    data_in_vector_enable = first;
    data_in_scalar_enable = !first;
    @(posedge CLK);
    #1;
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
    repeat (gap) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic run_job(int j);
    int errors_before;
    int results_before;
    int gap;
    errors_before = error_count;
    results_before = result_count;
    queue_expected(j);
    start = 1'b1;
    size_in = data_t'(job_size[j]);
    length_in = data_t'(job_length[j]);
    @(posedge CLK);
    #1;
    start = 1'b0;
    for (int v = 0; v < job_size[j]; v++) begin
      for (int e = 0; e < job_length[j]; e++) begin
        // Gaps between elements on random jobs only
        gap = 0;
        if (j >= TABLE_JOBS && e != job_length[j] - 1) begin
          gap = int'($urandom_range(1, 0));
        end
        send_element(score_of(job_scores[j][v], e), e == 0, gap);
      end
      // Next vector only after the last result of this one
      while (!data_out_vector_enable) begin
        @(posedge CLK);
        #1;
      end
    end
    // Monitor takes the final result on this cycle
    @(posedge CLK);
    #1;
    if (exp_data_q.size() != 0) begin
      $display("Job %0d ended with %0d results missing", j, exp_data_q.size());
      error_count++;
      exp_data_q.delete();
      exp_vec_q.delete();
      exp_rdy_q.delete();
    end
    $display("Test %0d %s job size %0d length %0d: %0d results, %0d errors", j + 1,
             (j < TABLE_JOBS) ? "table" : "random", job_size[j], job_length[j],
             result_count - results_before, error_count - errors_before);
  endtask

  ////////////////////
  // Result monitor
  ////////////////////

  // Outputs settle well before the falling edge
  initial begin : result_monitor
    data_t exp_data;
    logic  exp_vec;
    logic  exp_rdy;
    forever begin
      @(negedge CLK);
      if (!RST) begin
        if (data_out_scalar_enable) begin
          if (exp_data_q.size() == 0) begin
            $display("Unexpected result 0x%08h with no job pending", data_out);
            error_count++;
          end else begin
            exp_data = exp_data_q.pop_front();
            exp_vec = exp_vec_q.pop_front();
            exp_rdy = exp_rdy_q.pop_front();
            check_data("data_out", data_out, exp_data);
            check_flag("data_out_vector_enable", data_out_vector_enable, exp_vec);
            check_flag("ready", ready, exp_rdy);
            result_count++;
          end
        end else if (data_out_vector_enable || ready) begin
          $display("End flag raised without a result");
          error_count++;
        end
      end
    end
  end

  // Cycle budget for the whole run
  initial begin : timeout_watch
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d results outstanding", cycle_count,
             exp_data_q.size());
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main_sequence
    int limit;
    int errors_before;
    RST = 1'b1;
    start = 1'b0;
    size_in = '0;
    length_in = '0;
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
    data_in = '0;
    void'($urandom(32'he8cc15b1));
    load_table();
    make_random_jobs();
    limit = 200;
    for (int j = 0; j < NUM_JOBS; j++) begin
      limit += job_size[j] * job_length[j] * (DIV_CYCLES + 8);
    end
    cycle_limit = limit;

    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;

    // No strobe may appear before a start
    errors_before = error_count;
    repeat (20) @(posedge CLK);
    #1;
    $display("Test 0 idle after reset: %0d errors", error_count - errors_before);

    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end

    error_count += u_softmax_vector_function.u_softmax_tb_assertions.failures;
    $display("Tests %0d, results %0d, checks %0d, errors %0d", NUM_JOBS + 1,
             result_count, check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: softmax_tb_assertions.sv
// Vector controller strobe checks
`timescale 1ns/100ps
`default_nettype none

module softmax_tb_assertions
  import softmax_pkg::*;
(
  input logic          CLK,
  input logic          RST,
  input vector_state_t state,
  input logic          data_in_vector_enable,
  input logic          data_in_scalar_enable,
  input logic          data_out_vector_enable,
  input logic          data_out_scalar_enable,
  input logic          ready
);

  // Failed assertions so far
  int failures = 0;

  ////////////////////
  // Input rule
  ////////////////////

  // Elements are dropped while a vector drains
  drain_quiet: assert property (@(posedge CLK) disable iff (RST)
    (state == vector_drain) |-> !(data_in_vector_enable || data_in_scalar_enable))
  else begin
    $error("Element strobe while the controller drains");
    failures++;
  end

  ////////////////////
  // Output strobes
  ////////////////////

  // Job end only on a vector end
  ready_on_vector: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_vector_enable)
  else begin
    $error("ready without data_out_vector_enable");
    failures++;
  end

  // Vector end only on a result
  vector_on_result: assert property (@(posedge CLK) disable iff (RST)
    data_out_vector_enable |-> data_out_scalar_enable)
  else begin
    $error("data_out_vector_enable without data_out_scalar_enable");
    failures++;
  end

  // All quiet in reset
  reset_quiet: assert property (@(posedge CLK)
    RST |-> !(ready || data_out_vector_enable || data_out_scalar_enable))
  else begin
    $error("Output strobe during reset");
    failures++;
  end

endmodule

bind softmax_vector_function softmax_tb_assertions u_softmax_tb_assertions (
  .CLK                    (CLK),
  .RST                    (RST),
  .state                  (state),
  .data_in_vector_enable  (data_in_vector_enable),
  .data_in_scalar_enable  (data_in_scalar_enable),
  .data_out_vector_enable (data_out_vector_enable),
  .data_out_scalar_enable (data_out_scalar_enable),
  .ready                  (ready)
);

`default_nettype wire

// File: softmax_vector_function.sv
// Softmax vector controller
`timescale 1ns/100ps
`default_nettype none

module softmax_vector_function
  import softmax_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  input  data_t size_in,
  input  data_t length_in,
  input  logic  data_in_vector_enable,
  input  logic  data_in_scalar_enable,
  input  data_t data_in,
  output logic  data_out_vector_enable,
  output logic  data_out_scalar_enable,
  output data_t data_out,
  output logic  ready
);

  vector_state_t state;

  // Job shape, sampled on start
  index_t size_q;
  index_t length_q;
  // Vectors done and elements taken in the current vector
  index_t vector_idx_q;
  index_t elem_idx_q;

  // Scalar unit side
  logic scalar_start;
  logic scalar_data_in_enable;
  data_t scalar_data_in;
  logic scalar_data_out_enable;
  data_t scalar_data_out;
  logic scalar_ready;

  logic first_elem;
  logic next_elem;
  logic elem_accept;
  index_t accept_idx;
  logic last_elem;
  logic last_vector;

  ////////////////////
  // Element accept
  ////////////////////

  // Vector strobe opens a vector
  assign first_elem = (state == vector_collect) && data_in_vector_enable;
  // Scalar strobe only after the first element
  assign next_elem = (state == vector_collect) && data_in_scalar_enable &&
                     (elem_idx_q != '0);
  assign elem_accept = first_elem || next_elem;

  // Position of the element taken this cycle
  assign accept_idx = first_elem ? '0 : elem_idx_q;
  assign last_elem = (accept_idx == (length_q - index_t'(1)));
  assign last_vector = (vector_idx_q == (size_q - index_t'(1)));

  // Element word to the scalar unit
  always_ff @(posedge CLK) begin
    if (elem_accept) begin
      scalar_data_in <= data_in;
    end
  end

  // Control FSM and output registers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= vector_idle;
      size_q <= '0;
      length_q <= '0;
      vector_idx_q <= '0;
      elem_idx_q <= '0;
      scalar_start <= 1'b0;
      scalar_data_in_enable <= 1'b0;
      data_out_vector_enable <= 1'b0;
      data_out_scalar_enable <= 1'b0;
      data_out <= '0;
      ready <= 1'b0;
    end else begin
      // Strobes last one cycle
      scalar_start <= 1'b0;
      scalar_data_in_enable <= 1'b0;
      data_out_vector_enable <= 1'b0;
      ready <= 1'b0;

      // Forward every result one cycle late
      data_out_scalar_enable <= scalar_data_out_enable;
      if (scalar_data_out_enable) begin
        data_out <= scalar_data_out;
      end

      case (state)
        vector_idle: begin
          if (start) begin
            size_q <= size_in[INDEX_SIZE-1:0];
            length_q <= length_in[INDEX_SIZE-1:0];
            vector_idx_q <= '0;
            elem_idx_q <= '0;
            state <= vector_collect;
          end
        end
        vector_collect: begin
          if (elem_accept) begin
            // Start travels with the first element
            scalar_start <= first_elem;
            scalar_data_in_enable <= 1'b1;
            elem_idx_q <= accept_idx + 1'b1;
            if (last_elem) begin
              state <= vector_drain;
            end
          end
        end
        vector_drain: begin
          // Wait for the vector's last result
          if (scalar_ready) begin
            data_out_vector_enable <= 1'b1;
            elem_idx_q <= '0;
            if (last_vector) begin
              ready <= 1'b1;
              state <= vector_finish;
            end else begin
              vector_idx_q <= vector_idx_q + 1'b1;
              state <= vector_collect;
            end
          end
        end
        vector_finish: begin
          state <= vector_idle;
        end
        default: begin
          state <= vector_idle;
        end
      endcase
    end
  end

  ////////////////////
  // Scalar softmax
  ////////////////////

  softmax_scalar_unit u_softmax_scalar_unit (
    .CLK             (CLK),
    .RST             (RST),
    .start           (scalar_start),
    .length_in       (length_q),
    .data_in_enable  (scalar_data_in_enable),
    .data_in         (scalar_data_in),
    .data_out_enable (scalar_data_out_enable),
    .data_out        (scalar_data_out),
    .ready           (scalar_ready)
  );

endmodule

`default_nettype wire

// File: softmax_scalar_unit.sv
// Scalar softmax unit
`timescale 1ns/100ps
`default_nettype none

module softmax_scalar_unit
  import softmax_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   start,
  input  index_t length_in,
  input  logic   data_in_enable,
  input  data_t  data_in,
  output logic   data_out_enable,
  output data_t  data_out,
  output logic   ready
);

  scalar_state_t state;

  // Vector length latched on start
  index_t length_q;
  // Elements stored so far
  index_t count_q;
  // Next element to divide
  index_t rd_idx_q;
  // Running sum of powers of two
  data_t sum_q;
  // Quotient in flight belongs to the last element
  logic last_q;

  // Scores of the current vector
  logic [SCORE_BITS-1:0] score_mem [MAX_LENGTH];

  logic [SCORE_BITS-1:0] score_in;
  logic [SCORE_BITS-1:0] rd_score;
  data_t power_in;
  logic store_en;
  logic [ADDR_BITS-1:0] wr_addr;

  // Divider hookup
  logic div_start;
  logic div_done;
  data_t dividend;
  data_t quotient;

  ////////////////////
  // Element path
  ////////////////////

  assign score_in = data_in[SCORE_BITS-1:0];
  // 2^score
  assign power_in = data_t'(1) << score_in;

  // First element comes with start
  assign store_en = data_in_enable && (start || (state == scalar_load));
  assign wr_addr = start ? '0 : count_q[ADDR_BITS-1:0];

  always_ff @(posedge CLK) begin
    if (start) begin
      for (int i = 0; i < MAX_LENGTH; i++) begin
        score_mem[i] <= '0;
      end
    end
    if (store_en) begin
      score_mem[wr_addr] <= score_in;
    end
  end

  ////////////////////
  // Division path
  ////////////////////

  assign rd_score = score_mem[rd_idx_q[ADDR_BITS-1:0]];
  // Numerator 2^(score+FRAC_BITS)
  assign dividend = data_t'(1) << (FRAC_BITS + int'(rd_score));

  // First quotient launched from sum, the rest straight from emit
  assign div_start = (state == scalar_sum) || ((state == scalar_emit) && !last_q);

  softmax_divider u_softmax_divider (
    .CLK       (CLK),
    .RST       (RST),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (sum_q),
    .quotient  (quotient),
    .div_done  (div_done)
  );

  // Result word
  always_ff @(posedge CLK) begin
    if (div_done) begin
      data_out <= quotient;
    end
  end

  assign data_out_enable = (state == scalar_emit);
  assign ready = (state == scalar_emit) && last_q;

  // Control FSM
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= scalar_idle;
      length_q <= '0;
      count_q <= '0;
      rd_idx_q <= '0;
      sum_q <= '0;
      last_q <= 1'b0;
    end else if (start) begin
      // Restart, possibly with the first element
      length_q <= length_in;
      rd_idx_q <= '0;
      last_q <= 1'b0;
      count_q <= data_in_enable ? index_t'(1) : '0;
      sum_q <= data_in_enable ? power_in : '0;
      if (data_in_enable && (length_in == index_t'(1))) begin
        state <= scalar_sum;
      end else begin
        state <= scalar_load;
      end
    end else begin
      case (state)
        scalar_load: begin
          if (data_in_enable) begin
            count_q <= count_q + 1'b1;
            sum_q <= sum_q + power_in;
            // Sum complete with this element
            if ((count_q + index_t'(1)) == length_q) begin
              state <= scalar_sum;
            end
          end
        end
        scalar_sum: begin
          state <= scalar_divide;
        end
        scalar_divide: begin
          if (div_done) begin
            last_q <= (rd_idx_q == (length_q - index_t'(1)));
            rd_idx_q <= rd_idx_q + 1'b1;
            state <= scalar_emit;
          end
        end
        scalar_emit: begin
          if (last_q) begin
            state <= scalar_idle;
          end else begin
            state <= scalar_divide;
          end
        end
        default: begin
          state <= scalar_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: softmax_divider.sv
// Restoring divider
`timescale 1ns/100ps
`default_nettype none

module softmax_divider
  import softmax_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  div_start,
  input  data_t dividend,
  input  data_t divisor,
  output data_t quotient,
  output logic  div_done
);

  // Partial remainder with one spare bit for the trial subtract
  logic [DATA_SIZE:0] rem_q;
  // Dividend shifts out on top as quotient bits shift in below
  data_t quo_q;
  data_t divisor_q;
  logic [DIV_COUNT_BITS-1:0] count_q;
  logic busy_q;

  logic [DATA_SIZE:0] shifted;
  logic [DATA_SIZE:0] trial;
  logic fits;
  logic load;
  logic step;
  logic finish;

  ////////////////////
  // Trial subtract
  ////////////////////

  // Bring down the next dividend bit
  assign shifted = {rem_q[DATA_SIZE-1:0], quo_q[DATA_SIZE-1]};
  assign trial = shifted - {1'b0, divisor_q};
  // No borrow means the divisor fits
  assign fits = ~trial[DATA_SIZE];

  // Start only taken while idle
  assign load = div_start && !busy_q;
  // One quotient bit on every busy cycle
  assign step = busy_q;
  // Last quotient bit goes in on this step
  assign finish = busy_q && (count_q == DIV_COUNT_BITS'(DIV_CYCLES - 1));

  // Quotient held in the shift register after the last step
  assign quotient = quo_q;

  // Control and done strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q <= 1'b0;
      count_q <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        count_q <= '0;
      end else if (finish) begin
        // Done rises as the last bit lands
        busy_q <= 1'b0;
        div_done <= 1'b1;
      end else if (step) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Shift registers
  always_ff @(posedge CLK) begin
    if (load) begin
      rem_q <= '0;
      quo_q <= dividend;
      divisor_q <= divisor;
    end else if (step) begin
      rem_q <= fits ? trial : shifted;
      quo_q <= {quo_q[DATA_SIZE-2:0], fits};
    end
  end

endmodule

`default_nettype wire

// File: softmax_pkg.sv
// Softmax shared definitions
`default_nettype none

package softmax_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Width of every data and count word
  localparam int DATA_SIZE = 32;
  // Element and vector counters
  localparam int INDEX_SIZE = 8;
  // Element slots in the scalar buffer
  localparam int MAX_LENGTH = 16;
  localparam int ADDR_BITS = $clog2(MAX_LENGTH);

  // Low bits of an input word taken as the score
  localparam int SCORE_BITS = 4;
  // Fraction bits of a result, 2^(15+16) still fits in a word
  localparam int FRAC_BITS = 16;

  // Divider runs one quotient bit per cycle
  localparam int DIV_CYCLES = DATA_SIZE;
  localparam int DIV_COUNT_BITS = $clog2(DIV_CYCLES + 1);

  ////////////////////
  // Types
  ////////////////////

  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [INDEX_SIZE-1:0] index_t;

  // Vector controller FSM
  typedef enum logic [1:0] {
    vector_idle,
    vector_collect,
    vector_drain,
    vector_finish
  } vector_state_t;

  // Scalar unit FSM
  typedef enum logic [2:0] {
    scalar_idle,
    scalar_load,
    scalar_sum,
    scalar_divide,
    scalar_emit
  } scalar_state_t;

endpackage

`default_nettype wire
